// File: common/mic_pkg.sv
package mic_pkg;

    // microphone sample format
    localparam int sample_width = 24;
    typedef logic signed [sample_width-1:0] sample_t;

    // i2s clocking, clk_in cycles per sck level and sck periods per ws level
    localparam int sck_half_period = 2;
    localparam int bits_per_half_frame = 32;
    localparam int sck_cnt_width = $clog2(sck_half_period);
    localparam int bit_cnt_width = $clog2(bits_per_half_frame);
    localparam logic [sck_cnt_width-1:0] sck_half_last = sck_cnt_width'(sck_half_period - 1);
    localparam logic [bit_cnt_width-1:0] bit_last = bit_cnt_width'(bits_per_half_frame - 1);

    // receiver, last captured bit position after ws falls
    localparam logic [bit_cnt_width-1:0] rx_last_pos = bit_cnt_width'(sample_width);
    // no sck_rise for a full sck period means the clock was stopped
    localparam int rx_idle_width = 3;
    localparam logic [rx_idle_width-1:0] rx_idle_limit = rx_idle_width'(2 * sck_half_period);

    // fir, coefficient sum 8 so the accumulator needs 3 extra bits
    localparam int fir_shift = 3;
    localparam int fir_acc_width = sample_width + fir_shift;
    typedef logic signed [fir_acc_width-1:0] fir_acc_t;

    // decimation factor field
    localparam int decim_width = 4;

    // sample fifo
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_count_width = fifo_ptr_width + 1;
    localparam logic [fifo_count_width-1:0] fifo_full_count = fifo_count_width'(fifo_depth);

    // axi4-lite register map
    localparam int axil_addr_width = 4;
    localparam int axil_data_width = 32;
    localparam logic [axil_addr_width-1:0] addr_ctrl = 4'h0;
    localparam logic [axil_addr_width-1:0] addr_status = 4'h4;
    localparam logic [axil_addr_width-1:0] addr_data = 4'h8;
    localparam logic [1:0] axil_resp_okay = 2'b00;
    typedef logic [axil_data_width-1:0] axil_word_t;

    typedef struct packed {
        logic enable;
        logic [decim_width-1:0] decim_factor;
    } mic_cfg_t;

    typedef struct packed {
        logic [fifo_count_width-1:0] count;
        logic overflow;
    } fifo_status_t;

    typedef struct packed {
        logic [axil_addr_width-1:0] awaddr;
        logic awvalid;
        logic [axil_data_width-1:0] wdata;
        logic [3:0] wstrb;
        logic wvalid;
        logic bready;
        logic [axil_addr_width-1:0] araddr;
        logic arvalid;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic [1:0] bresp;
        logic bvalid;
        logic arready;
        logic [axil_data_width-1:0] rdata;
        logic [1:0] rresp;
        logic rvalid;
    } axil_rsp_t;

endpackage

// File: i2s/i2s_clock_gen.sv
`timescale 1ns/1ns

module i2s_clock_gen (
    input logic clk_in,
    input logic arst_n,
    input logic enable,
    output logic sck,
    output logic ws,
    output logic sck_rise
);

    // clk_in cycles within one sck level
    logic [mic_pkg::sck_cnt_width-1:0] half_cnt;
    // falling sck edges within one ws level
    logic [mic_pkg::bit_cnt_width-1:0] bit_cnt;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            half_cnt <= '0;
            bit_cnt <= '0;
            sck <= 1'b0;
            ws <= 1'b0;
            sck_rise <= 1'b0;
        end else if (!enable) begin
            // parked low, next enable starts a fresh left half
            half_cnt <= '0;
            bit_cnt <= '0;
            sck <= 1'b0;
            ws <= 1'b0;
            sck_rise <= 1'b0;
        end else begin
            sck_rise <= 1'b0;
            if (half_cnt == mic_pkg::sck_half_last) begin
                half_cnt <= '0;
                sck <= ~sck;
                // strobe lines up with the first cycle of sck high
                sck_rise <= ~sck;
                if (sck) begin
                    // falling edge, ws moves only here
                    if (bit_cnt == mic_pkg::bit_last) begin
                        bit_cnt <= '0;
                        ws <= ~ws;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // ws transitions sit on falling sck while running
    ws_on_sck_fall: assert property (@(posedge clk_in) disable iff (!arst_n)
        ($past(enable) && $changed(ws)) |-> $fell(sck));

endmodule

// File: i2s/i2s_receiver.sv
`timescale 1ns/1ns

module i2s_receiver (
    input logic clk_in,
    input logic arst_n,
    input logic ws,
    input logic sck_rise,
    input logic sd,
    output mic_pkg::sample_t sample,
    output logic sample_valid
);

    // rising sck count since ws fell, position 0 is the delay bit
    logic [mic_pkg::bit_cnt_width-1:0] pos_cnt;
    logic [mic_pkg::bit_cnt_width-1:0] pos_now;
    // cycles since the last sck_rise
    logic [mic_pkg::rx_idle_width-1:0] idle_cnt;
    logic idle;
    logic capture;

    // stopped clock means disabled, realign to a new frame
    assign idle = (idle_cnt == mic_pkg::rx_idle_limit);
    assign pos_now = idle ? '0 : pos_cnt;
    // bits 23..0 at positions 1..24 of the left half
    assign capture = !ws && sck_rise && (pos_now != '0) && (pos_now <= mic_pkg::rx_last_pos);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pos_cnt <= '0;
            idle_cnt <= '0;
            sample_valid <= 1'b0;
        end else begin
            if (sck_rise) begin
                idle_cnt <= '0;
            end else if (!idle) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            // right half holds the counter at zero
            if (ws) begin
                pos_cnt <= '0;
            end else if (sck_rise) begin
                pos_cnt <= pos_now + 1'b1;
            end else begin
                pos_cnt <= pos_now;
            end
            // one cycle after bit 0 is captured
            sample_valid <= capture && (pos_now == mic_pkg::rx_last_pos);
        end
    end

    // msb first shift, word is complete when sample_valid is high
    always_ff @(posedge clk_in) begin
        if (capture) begin
            sample <= {sample[mic_pkg::sample_width-2:0], sd};
        end
    end

    // at most one sample per frame
    single_valid: assert property (@(posedge clk_in) disable iff (!arst_n)
        sample_valid |=> !sample_valid);

endmodule

// File: rtl/fir_decimator.sv
`timescale 1ns/1ns

module fir_decimator (
    input logic clk_in,
    input logic arst_n,
    input mic_pkg::mic_cfg_t cfg,
    input mic_pkg::sample_t in_sample,
    input logic in_valid,
    output mic_pkg::sample_t out_sample,
    output logic out_valid
);

    // x1 newest previous sample, x3 oldest
    mic_pkg::sample_t x1;
    mic_pkg::sample_t x2;
    mic_pkg::sample_t x3;
    mic_pkg::fir_acc_t x0_ext;
    mic_pkg::fir_acc_t x1_ext;
    mic_pkg::fir_acc_t x2_ext;
    mic_pkg::fir_acc_t x3_ext;
    mic_pkg::fir_acc_t acc;
    mic_pkg::fir_acc_t acc_shift;
    // keep-one-in-N counter
    logic [mic_pkg::decim_width-1:0] dec_cnt;
    logic [mic_pkg::decim_width-1:0] dec_last;

    // sign extension into the accumulator width
    assign x0_ext = mic_pkg::fir_acc_t'(in_sample);
    assign x1_ext = mic_pkg::fir_acc_t'(x1);
    assign x2_ext = mic_pkg::fir_acc_t'(x2);
    assign x3_ext = mic_pkg::fir_acc_t'(x3);

    // taps 1 3 3 1, times 3 as x + 2x
    assign acc = x0_ext + x1_ext + (x1_ext <<< 1) + x2_ext + (x2_ext <<< 1) + x3_ext;
    // divide by the coefficient sum, result fits the sample width again
    assign acc_shift = acc >>> mic_pkg::fir_shift;

    assign dec_last = cfg.decim_factor - 1'b1;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            x1 <= '0;
            x2 <= '0;
            x3 <= '0;
            dec_cnt <= '0;
            out_valid <= 1'b0;
        end else if (!cfg.enable) begin
            // zero history and counter so the first result after enable is kept
            x1 <= '0;
            x2 <= '0;
            x3 <= '0;
            dec_cnt <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && (dec_cnt == '0);
            if (in_valid) begin
                x1 <= in_sample;
                x2 <= x1;
                x3 <= x2;
                // >= so a lowered factor mid-run still wraps
                if (dec_cnt >= dec_last) begin
                    dec_cnt <= '0;
                end else begin
                    dec_cnt <= dec_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (in_valid) begin
            out_sample <= acc_shift[mic_pkg::sample_width-1:0];
        end
    end

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
    input logic clk_in,
    input logic arst_n,
    input mic_pkg::sample_t wr_sample,
    input logic wr_valid,
    input logic pop,
    output mic_pkg::sample_t head,
    output mic_pkg::fifo_status_t status,
    input logic clear_overflow
);

    mic_pkg::sample_t mem [mic_pkg::fifo_depth];
    logic [mic_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [mic_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [mic_pkg::fifo_count_width-1:0] count;
    logic overflow;
    logic full;
    logic do_pop;
    logic do_wr;

    assign full = (count == mic_pkg::fifo_full_count);
    // pop on empty is ignored
    assign do_pop = pop && (count != '0);
    // a pop frees the slot in the same cycle
    assign do_wr = wr_valid && (!full || do_pop);

    assign head = mem[rd_ptr];
    assign status.count = count;
    assign status.overflow = overflow;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_wr) begin
                count <= count - 1'b1;
            end
            // dropped sample wins over a clear in the same cycle
            if (wr_valid && !do_wr) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_sample;
        end
    end

    count_bound: assert property (@(posedge clk_in) disable iff (!arst_n)
        count <= mic_pkg::fifo_full_count);

endmodule

// File: rtl/mic_regs.sv
`timescale 1ns/1ns

module mic_regs (
    input logic clk_in,
    input logic arst_n,
    input mic_pkg::axil_req_t axil_req,
    output mic_pkg::axil_rsp_t axil_rsp,
    output mic_pkg::mic_cfg_t cfg,
    input mic_pkg::fifo_status_t status,
    input mic_pkg::sample_t head,
    output logic pop,
    output logic clear_overflow
);

    logic wr_accept;
    logic rd_accept;
    logic bvalid;
    logic rvalid;
    mic_pkg::axil_word_t rdata;
    mic_pkg::axil_word_t rd_word;
    logic [mic_pkg::decim_width-1:0] wr_factor;

    // write needs both address and data, one outstanding response
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_accept = axil_req.arvalid && !rvalid;

    // ctrl factor in bits 7:4, zero means keep every sample
    assign wr_factor = (axil_req.wdata[7:4] == '0) ? 4'd1 : axil_req.wdata[7:4];

    // status bit 8 written as one clears the sticky overflow
    assign clear_overflow = wr_accept && (axil_req.awaddr == mic_pkg::addr_status) &&
        axil_req.wstrb[1] && axil_req.wdata[8];

    // data read consumes the head only when something is there
    assign pop = rd_accept && (axil_req.araddr == mic_pkg::addr_data) && (status.count != '0);

    // read mux
    always_comb begin
        rd_word = '0;
        case (axil_req.araddr)
            mic_pkg::addr_ctrl: begin
                rd_word[0] = cfg.enable;
                rd_word[7:4] = cfg.decim_factor;
            end
            mic_pkg::addr_status: begin
                rd_word[2:0] = status.count;
                rd_word[8] = status.overflow;
            end
            mic_pkg::addr_data: begin
                // sign extended, empty fifo reads zero
                if (status.count != '0) begin
                    rd_word = mic_pkg::axil_word_t'(head);
                end
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            cfg.enable <= 1'b0;
            cfg.decim_factor <= 4'd1;
        end else begin
            // response holds until the host takes it
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
            if (wr_accept && (axil_req.awaddr == mic_pkg::addr_ctrl) && axil_req.wstrb[0]) begin
                cfg.enable <= axil_req.wdata[0];
                cfg.decim_factor <= wr_factor;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

    always_comb begin
        axil_rsp = '0;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready = wr_accept;
        axil_rsp.bresp = mic_pkg::axil_resp_okay;
        axil_rsp.bvalid = bvalid;
        axil_rsp.arready = rd_accept;
        axil_rsp.rdata = rdata;
        axil_rsp.rresp = mic_pkg::axil_resp_okay;
        axil_rsp.rvalid = rvalid;
    end

    bvalid_hold: assert property (@(posedge clk_in) disable iff (!arst_n)
        (bvalid && !axil_req.bready) |=> bvalid);

endmodule

// File: rtl/microphones.sv
`timescale 1ns/1ns

module microphones (
    input logic clk_in,
    input logic arst_n,

    // i2s microphone pins
    input logic mic_data,
    output logic mic_sck,
    output logic mic_ws,

    // host register port
    input mic_pkg::axil_req_t axil_req,
    output mic_pkg::axil_rsp_t axil_rsp
);

    mic_pkg::mic_cfg_t cfg;
    logic sck_rise;
    mic_pkg::sample_t rx_sample;
    logic rx_valid;
    mic_pkg::sample_t fir_sample;
    logic fir_valid;
    mic_pkg::sample_t fifo_head;
    mic_pkg::fifo_status_t fifo_status;
    logic fifo_pop;
    logic clear_overflow;

    // sck and ws for the microphone, stopped while disabled
    i2s_clock_gen i2s_clock_gen_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .enable(cfg.enable),
        .sck(mic_sck),
        .ws(mic_ws),
        .sck_rise(sck_rise)
    );

    // left channel capture only
    i2s_receiver i2s_receiver_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .ws(mic_ws),
        .sck_rise(sck_rise),
        .sd(mic_data),
        .sample(rx_sample),
        .sample_valid(rx_valid)
    );

    // low-pass then keep one in N
    fir_decimator fir_decimator_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .cfg(cfg),
        .in_sample(rx_sample),
        .in_valid(rx_valid),
        .out_sample(fir_sample),
        .out_valid(fir_valid)
    );

    // audio never stalls, full fifo drops and flags
    sample_fifo sample_fifo_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .wr_sample(fir_sample),
        .wr_valid(fir_valid),
        .pop(fifo_pop),
        .head(fifo_head),
        .status(fifo_status),
        .clear_overflow(clear_overflow)
    );

    mic_regs mic_regs_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .cfg(cfg),
        .status(fifo_status),
        .head(fifo_head),
        .pop(fifo_pop),
        .clear_overflow(clear_overflow)
    );

endmodule

// File: bench/i2s_mic_model.sv
`timescale 1ns/1ns

module i2s_mic_model (
    input logic clk_in,
    input logic sck,
    input logic ws,
    input logic push,
    input mic_pkg::sample_t push_sample,
    input logic flush,
    output logic sd
);

    // words still to send, one per left half
    mic_pkg::sample_t words [$];
    mic_pkg::sample_t word = '0;
    logic sd_q = 1'b0;
    logic last_sck = 1'b0;
    // set once the delay slot of the current left half is past
    logic started = 1'b1;
    // falling sck count inside the left half, 1 carries bit 23
    int left_pos = 0;
    // falling clk_in edges without an sck change
    int idle_cnt = 0;

    assign sd = sd_q;

    // queue is updated on the rising edge, away from the falling-edge drive
    always @(posedge clk_in) begin
        if (flush) begin
            words.delete();
        end else if (push) begin
            words.push_back(push_sample);
        end
    end

    // sck and ws are stable here, data changes after a falling sck
    always @(negedge clk_in) begin
        if (sck != last_sck) begin
            idle_cnt = 0;
        end else if (idle_cnt < 8) begin
            idle_cnt = idle_cnt + 1;
        end
        if (idle_cnt >= 4) begin
            // stopped clock, next rising sck is the delay slot of a fresh left half
            started = 1'b1;
            left_pos = 0;
            sd_q <= 1'b0;
        end else if (last_sck && !sck) begin
            if (ws) begin
                // right half, nothing to send
                started = 1'b0;
                sd_q <= 1'b0;
            end else if (!started) begin
                // ws just fell, one-bit delay
                started = 1'b1;
                left_pos = 0;
                sd_q <= 1'b0;
            end else begin
                left_pos = left_pos + 1;
                if (left_pos == 1) begin
                    // empty queue sends silence
                    if (words.size() != 0) begin
                        word = words.pop_front();
                    end else begin
                        word = '0;
                    end
                end
                // msb first, zeros after bit 0
                if (left_pos <= mic_pkg::sample_width) begin
                    sd_q <= word[mic_pkg::sample_width - left_pos];
                end else begin
                    sd_q <= 1'b0;
                end
            end
        end
        last_sck = sck;
    end

endmodule

// File: bench/microphones_tb.sv
`timescale 1ns/1ns

module microphones_tb;

    // about 60 frames of 256 cycles for all phases plus wide margin
    localparam int max_cycles = 40000;

    logic clk_in;
    logic arst_n;
    logic mic_data;
    logic mic_sck;
    logic mic_ws;
    mic_pkg::axil_req_t axil_req;
    mic_pkg::axil_rsp_t axil_rsp;
    // microphone model queue control
    logic push;
    mic_pkg::sample_t push_sample;
    logic flush;

    integer seed = 32'hdf3e32bc;
    int cycle_cnt = 0;
    // samples sent since the last enable in frame order
    int stim [$];
    logic [31:0] rd_val;
    logic [31:0] st;

    microphones microphones_inst (
        .clk_in(clk_in),
        .arst_n(arst_n),
        .mic_data(mic_data),
        .mic_sck(mic_sck),
        .mic_ws(mic_ws),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    i2s_mic_model mic_model_inst (
        .clk_in(clk_in),
        .sck(mic_sck),
        .ws(mic_ws),
        .push(push),
        .push_sample(push_sample),
        .flush(flush),
        .sd(mic_data)
    );

    // 40 ns period
    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: samples did not arrive");
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // zero history before the first sample
    function automatic int tap(input int k);
        if (k < 0) begin
            return 0;
        end
        return stim[k];
    endfunction

    // low-pass 1 3 3 1 then divide by 8 with floor rounding
    function automatic int fir_expected(input int k);
        int acc;
        acc = tap(k) + 3 * tap(k - 1) + 3 * tap(k - 2) + tap(k - 3);
        return acc >>> 3;
    endfunction

    // address and data together then wait for the response
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk_in);
        axil_req.awaddr = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata = data;
        axil_req.wstrb = 4'hf;
        axil_req.wvalid = 1'b1;
        axil_req.bready = 1'b1;
        // bvalid is low so the write is taken on this edge
        @(posedge clk_in);
        check_value("awready", 32'(axil_rsp.awready), 32'h1);
        check_value("wready", 32'(axil_rsp.wready), 32'h1);
        @(negedge clk_in);
        while (!axil_rsp.bvalid) begin
            @(negedge clk_in);
        end
        check_value("bresp", 32'(axil_rsp.bresp), 32'(mic_pkg::axil_resp_okay));
        // accept strobe lasts one cycle only
        check_value("awready", 32'(axil_rsp.awready), 32'h0);
        check_value("wready", 32'(axil_rsp.wready), 32'h0);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        @(negedge clk_in);
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk_in);
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready = 1'b1;
        // rvalid is low so the read is taken on this edge
        @(posedge clk_in);
        check_value("arready", 32'(axil_rsp.arready), 32'h1);
        @(negedge clk_in);
        while (!axil_rsp.rvalid) begin
            @(negedge clk_in);
        end
        data = axil_rsp.rdata;
        check_value("rresp", 32'(axil_rsp.rresp), 32'(mic_pkg::axil_resp_okay));
        check_value("arready", 32'(axil_rsp.arready), 32'h0);
        axil_req.arvalid = 1'b0;
        @(negedge clk_in);
        axil_req.rready = 1'b0;
    endtask

    task automatic drain_fifo();
        logic [31:0] st_word;
        logic [31:0] data_word;
        read_reg(mic_pkg::addr_status, st_word);
        while (st_word[2:0] != 3'd0) begin
            read_reg(mic_pkg::addr_data, data_word);
            read_reg(mic_pkg::addr_status, st_word);
        end
    endtask

    task automatic wait_for_data();
        logic [31:0] st_word;
        read_reg(mic_pkg::addr_status, st_word);
        while (st_word[2:0] == 3'd0) begin
            read_reg(mic_pkg::addr_status, st_word);
        end
    endtask

    // full fifo with the sticky flag set
    task automatic wait_for_overflow();
        logic [31:0] st_word;
        read_reg(mic_pkg::addr_status, st_word);
        while (!(st_word[8] && st_word[2:0] == 3'(mic_pkg::fifo_depth))) begin
            read_reg(mic_pkg::addr_status, st_word);
        end
    endtask

    // fresh random words into the model and the reference list
    task automatic load_samples(input int count);
        logic [31:0] rnd;
        mic_pkg::sample_t raw;
        @(negedge clk_in);
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        stim.delete();
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            raw = rnd[23:0];
            push_sample = raw;
            push = 1'b1;
            stim.push_back(int'(raw));
            @(negedge clk_in);
        end
        push = 1'b0;
    endtask

    // disable clears fir history and counter and enable starts a new frame
    task automatic restart_capture(input logic [3:0] factor, input int count);
        write_reg(mic_pkg::addr_ctrl, {24'h0, factor, 4'h0});
        drain_fifo();
        load_samples(count);
        write_reg(mic_pkg::addr_ctrl, {24'h0, factor, 3'h0, 1'b1});
    endtask

    initial begin
        arst_n = 1'b0;
        axil_req = '0;
        push = 1'b0;
        push_sample = '0;
        flush = 1'b0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;

        // reset values and factor 0 stored as 1
        read_reg(mic_pkg::addr_status, rd_val);
        check_value("status", rd_val, 32'h0);
        read_reg(mic_pkg::addr_ctrl, rd_val);
        check_value("ctrl", rd_val, 32'h10);
        write_reg(mic_pkg::addr_ctrl, 32'h50);
        read_reg(mic_pkg::addr_ctrl, rd_val);
        check_value("ctrl", rd_val, 32'h50);
        write_reg(mic_pkg::addr_ctrl, 32'h0);
        read_reg(mic_pkg::addr_ctrl, rd_val);
        check_value("ctrl", rd_val, 32'h10);

        // every filtered sample kept
        restart_capture(4'd1, 14);
        for (int k = 0; k < 12; k++) begin
            wait_for_data();
            read_reg(mic_pkg::addr_data, rd_val);
            check_value("data", rd_val, fir_expected(k));
        end

        // one in three with the first one kept
        restart_capture(4'd3, 14);
        for (int j = 0; j < 4; j++) begin
            wait_for_data();
            read_reg(mic_pkg::addr_data, rd_val);
            check_value("data", rd_val, fir_expected(3 * j));
        end

        // no reads until full so later samples are dropped
        restart_capture(4'd1, 8);
        wait_for_overflow();
        for (int k = 0; k < mic_pkg::fifo_depth; k++) begin
            read_reg(mic_pkg::addr_data, rd_val);
            check_value("data", rd_val, fir_expected(k));
        end
        write_reg(mic_pkg::addr_status, 32'h100);
        read_reg(mic_pkg::addr_status, st);
        check_value("status.overflow", 32'(st[8]), 32'h0);

        // empty read gives zero and pops nothing
        write_reg(mic_pkg::addr_ctrl, 32'h10);
        drain_fifo();
        read_reg(mic_pkg::addr_data, rd_val);
        check_value("data", rd_val, 32'h0);
        read_reg(mic_pkg::addr_status, st);
        check_value("status.count", 32'(st[2:0]), 32'h0);

        // i2s pins parked while disabled
        repeat (100) begin
            @(negedge clk_in);
            check_value("mic_sck", 32'(mic_sck), 32'h0);
            check_value("mic_ws", 32'(mic_ws), 32'h0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: all.f
common/mic_pkg.sv
i2s/i2s_clock_gen.sv
i2s/i2s_receiver.sv
rtl/fir_decimator.sv
rtl/sample_fifo.sv
rtl/mic_regs.sv
rtl/microphones.sv
bench/i2s_mic_model.sv
bench/microphones_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the microphone front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module microphones_tb -o microphones_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/microphones_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
